/* rtl/busInterface.sv */
`timescale 1ns/100ps

module busInterface import cpuPkg::*; (
    input  logic fast_clock,
    input  logic reset,
    input  logic start,
    input  busRequest_t request,
    input  logic wbAck,
    input  logic [dataWidth-1:0] wbDatIn,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [addrWidth-1:0] wbAdr,
    output logic [dataWidth-1:0] wbDatOut,
    output logic done,
    output logic [dataWidth-1:0] readData
);

    typedef enum logic {busIdle, busActive} busState_t;

    busState_t state;
    logic launch;
    logic finish;

    assign launch = (state == busIdle) && start;
    assign finish = (state == busActive) && wbAck;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            state <= busIdle;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= finish;    // One cycle after ack
            if (launch) begin
                state <= busActive;
                wbCyc <= 1'b1;
                wbStb <= 1'b1;
                wbWe <= (request.kind == busStore);
            end else if (finish) begin
                state <= busIdle;
                wbCyc <= 1'b0;
                wbStb <= 1'b0;
                wbWe <= 1'b0;
            end
        end
    end

    // Address and data stay put for the whole cycle
    always_ff @(posedge fast_clock) begin
        if (launch) begin
            wbAdr <= request.address;
            wbDatOut <= request.storeData;
        end
        if (finish) begin
            readData <= wbDatIn;
        end
    end

    assert property (@(posedge fast_clock) disable iff (reset) wbStb |-> wbCyc);

    // Sequencer waits for done before the next request
    assert property (@(posedge fast_clock) disable iff (reset) start |-> !wbCyc);

endmodule

/* rtl/cpuCore.sv */
`timescale 1ns/100ps

module cpuCore import cpuPkg::*; (
    input  logic fast_clock,
    input  logic reset,
    input  logic wbAck,
    input  logic [dataWidth-1:0] wbDatIn,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [addrWidth-1:0] wbAdr,
    output logic [dataWidth-1:0] wbDatOut,
    output logic privileged,
    output logic halted
);

    decodedOp_t op;
    busRequest_t request;
    logic busStart;
    logic busDone;
    logic [dataWidth-1:0] busData;
    logic latch;
    logic writeEnable;
    logic enterPrivileged;
    logic leavePrivileged;
    logic [dataWidth-1:0] memoryData;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;
    logic [dataWidth-1:0] aluResult;
    logic [addrWidth-1:0] currentPc;
    logic [addrWidth-1:0] effectiveAddress;
    logic [addrWidth-1:0] nextPc;

    sequencer sequencer0 (
        .fast_clock(fast_clock), .reset(reset), .op(op),
        .busDone(busDone), .busData(busData), .currentPc(currentPc),
        .effectiveAddress(effectiveAddress), .storeData(readDataB),
        .busStart(busStart), .request(request), .latch(latch),
        .writeEnable(writeEnable), .enterPrivileged(enterPrivileged),
        .leavePrivileged(leavePrivileged), .privileged(privileged),
        .halted(halted), .memoryData(memoryData)
    );

    busInterface bus0 (
        .fast_clock(fast_clock), .reset(reset), .start(busStart), .request(request),
        .wbAck(wbAck), .wbDatIn(wbDatIn), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatOut(wbDatOut), .done(busDone), .readData(busData)
    );

    // Fetched word goes straight to the decoder latch
    instructionDecoder decoder0 (
        .fast_clock(fast_clock), .reset(reset), .latch(latch), .word(busData), .op(op)
    );

    registerBank bank0 (
        .fast_clock(fast_clock), .reset(reset), .privileged(privileged),
        .writeEnable(writeEnable), .op(op), .aluResult(aluResult),
        .memoryData(memoryData), .nextPc(nextPc),
        .enterPrivileged(enterPrivileged), .leavePrivileged(leavePrivileged),
        .readDataA(readDataA), .readDataB(readDataB), .currentPc(currentPc)
    );

    executeUnit execute0 (
        .op(op), .operandA(readDataA), .operandB(readDataB), .currentPc(currentPc),
        .aluResult(aluResult), .effectiveAddress(effectiveAddress),
        .branchTaken(), .nextPc(nextPc)    // Taken flag already folded into nextPc
    );

endmodule

/* rtl/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 14;    // Word addresses

    localparam logic [dataWidth-1:0] dataAreaStart = 32'h200;
    localparam logic [dataWidth-1:0] stackTop = '1;
    localparam logic [addrWidth-1:0] trapVector = 14'h100;

    localparam logic [3:0] linkIndex = 4'd13;
    localparam logic [3:0] stackIndex = 4'd14;
    localparam logic [3:0] pcIndex = 4'd15;

    // Codes 12 to 15 are undefined and decode as HALT
    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr, opXor, opAddi,
        opLoad, opStore, opBeqz, opTrap, opRtu, opHalt
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        logic [3:0] rd;
        logic [3:0] rsA;
        logic [3:0] rsB;
        logic [15:0] reserved;
    } regFormat_t;

    typedef struct packed {
        opcode_t opcode;
        logic [3:0] rd;
        logic [3:0] rsA;
        logic [3:0] unused;    // Sits where rsB is in register format
        logic [15:0] imm16;
    } immFormat_t;

    typedef union packed {
        regFormat_t regForm;
        immFormat_t immForm;
    } instruction_t;

    // Write-back source for rd
    typedef enum logic [2:0] {wbNone, wbAlu, wbMemory, wbResetBase} wbSelect_t;

    typedef struct packed {
        opcode_t opcode;
        logic [3:0] rd;
        logic [3:0] rsA;
        logic [3:0] rsB;
        logic [dataWidth-1:0] immediate;    // Already sign-extended
        logic useImmediate;
        wbSelect_t wbSelect;
        logic isLoad;
        logic isStore;
        logic isBranch;
        logic isTrap;
        logic isReturn;
        logic isHalt;
    } decodedOp_t;

    typedef enum logic [1:0] {busFetch, busLoad, busStore} busKind_t;

    typedef struct packed {
        busKind_t kind;
        logic [addrWidth-1:0] address;
        logic [dataWidth-1:0] storeData;
    } busRequest_t;

endpackage

/* rtl/executeUnit.sv */
`timescale 1ns/100ps

module executeUnit import cpuPkg::*; (
    input  decodedOp_t op,
    input  logic [dataWidth-1:0] operandA,
    input  logic [dataWidth-1:0] operandB,
    input  logic [addrWidth-1:0] currentPc,
    output logic [dataWidth-1:0] aluResult,
    output logic [addrWidth-1:0] effectiveAddress,
    output logic branchTaken,
    output logic [addrWidth-1:0] nextPc
);

    logic [dataWidth-1:0] secondOperand;
    logic [dataWidth-1:0] addressSum;
    logic [addrWidth-1:0] pcPlusOne;

    assign secondOperand = op.useImmediate ? op.immediate : operandB;

    always_comb begin
        case (op.opcode)
            opSub: aluResult = operandA - secondOperand;
            opAnd: aluResult = operandA & secondOperand;
            opOr: aluResult = operandA | secondOperand;
            opXor: aluResult = operandA ^ secondOperand;
            default: aluResult = operandA + secondOperand;    // ADD, ADDI
        endcase
    end

    // Word address from rsA plus offset
    assign addressSum = operandA + op.immediate;
    assign effectiveAddress = addressSum[addrWidth-1:0];

    assign pcPlusOne = currentPc + addrWidth'(1);
    assign branchTaken = op.isBranch && (operandA == '0);

    always_comb begin
        if (op.isTrap) begin
            nextPc = trapVector;
        end else if (op.isReturn) begin
            nextPc = operandA[addrWidth-1:0];
        end else if (branchTaken) begin
            nextPc = pcPlusOne + op.immediate[addrWidth-1:0];
        end else begin
            nextPc = pcPlusOne;
        end
    end

endmodule

/* rtl/instructionDecoder.sv */
`timescale 1ns/100ps

module instructionDecoder import cpuPkg::*; (
    input  logic fast_clock,
    input  logic reset,
    input  logic latch,
    input  instruction_t word,
    output decodedOp_t op
);

    instruction_t held;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            held <= '0;
        end else if (latch) begin
            held <= word;
        end
    end

    always_comb begin
        op = '0;
        op.opcode = opHalt;
        op.wbSelect = wbNone;
        case (held.regForm.opcode)
            opAdd, opSub, opAnd, opOr, opXor: begin
                op.opcode = held.regForm.opcode;
                op.rd = held.regForm.rd;
                op.rsA = held.regForm.rsA;
                op.rsB = held.regForm.rsB;
                op.wbSelect = wbAlu;
            end
            opAddi, opLoad, opStore, opBeqz: begin
                op.opcode = held.immForm.opcode;
                op.rd = held.immForm.rd;
                op.rsA = held.immForm.rsA;
                op.rsB = held.immForm.rd;    // Store data register
                op.immediate = {{16{held.immForm.imm16[15]}}, held.immForm.imm16};
                op.useImmediate = 1'b1;
                op.isLoad = (held.immForm.opcode == opLoad);
                op.isStore = (held.immForm.opcode == opStore);
                op.isBranch = (held.immForm.opcode == opBeqz);
                if (held.immForm.opcode == opAddi) begin
                    op.wbSelect = wbAlu;
                end else if (held.immForm.opcode == opLoad) begin
                    op.wbSelect = wbMemory;
                end
            end
            opTrap: begin
                op.opcode = opTrap;
                op.isTrap = 1'b1;
            end
            opRtu: begin
                op.opcode = opRtu;
                op.rsA = linkIndex;    // Jump target comes from r13
                op.isReturn = 1'b1;
            end
            default: begin
                op.isHalt = 1'b1;
            end
        endcase
    end

endmodule

/* rtl/registerBank.sv */
`timescale 1ns/100ps

module registerBank import cpuPkg::*; (
    input  logic fast_clock,
    input  logic reset,
    input  logic privileged,
    input  logic writeEnable,
    input  decodedOp_t op,
    input  logic [dataWidth-1:0] aluResult,
    input  logic [dataWidth-1:0] memoryData,
    input  logic [addrWidth-1:0] nextPc,
    input  logic enterPrivileged,
    input  logic leavePrivileged,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB,
    output logic [addrWidth-1:0] currentPc
);

    logic [dataWidth-1:0] regs [0:linkIndex];    // r0 to r13
    logic [dataWidth-1:0] userStack;
    logic [dataWidth-1:0] privStack;
    logic [addrWidth-1:0] pcReg;
    logic [addrWidth-1:0] pcPlusOne;
    logic readMode;
    logic [dataWidth-1:0] writeValue;
    logic writeActive;

    assign currentPc = pcReg;
    assign pcPlusOne = pcReg + addrWidth'(1);

    // Mode in force once a pending switch has landed
    assign readMode = enterPrivileged ? 1'b1 : (leavePrivileged ? 1'b0 : privileged);

    assign writeActive = (op.wbSelect == wbAlu) || (op.wbSelect == wbMemory);
    assign writeValue = (op.wbSelect == wbMemory) ? memoryData : aluResult;

    function automatic logic [dataWidth-1:0] readReg(input logic [3:0] index);
        logic [dataWidth-1:0] value;
        if (index == pcIndex) begin
            value = dataWidth'(pcPlusOne);    // Address of the following instruction
        end else if (index == stackIndex) begin
            value = readMode ? privStack : userStack;
        end else begin
            value = regs[index];
        end
        return value;
    endfunction

    always_ff @(posedge fast_clock) begin
        readDataA <= readReg(op.rsA);
        readDataB <= readReg(op.rsB);
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            pcReg <= '0;
            userStack <= stackTop;
            privStack <= stackTop;
            regs[0] <= dataAreaStart;
        end else if (writeEnable) begin
            pcReg <= nextPc;
            if (enterPrivileged) begin
                regs[linkIndex] <= dataWidth'(pcPlusOne);    // Return address
            end
            if (op.wbSelect == wbResetBase) begin
                regs[0] <= dataAreaStart;
            end
            if (writeActive) begin
                if (op.rd == stackIndex) begin
                    // Stack of the mode the instruction ran in
                    if (privileged) begin
                        privStack <= writeValue;
                    end else begin
                        userStack <= writeValue;
                    end
                end else if (op.rd != pcIndex) begin
                    regs[op.rd] <= writeValue;    // r15 writes are dropped
                end
            end
        end
    end

    assert property (@(posedge fast_clock) disable iff (reset)
        !(enterPrivileged && leavePrivileged));

endmodule

/* rtl/sequencer.sv */
`timescale 1ns/100ps

module sequencer import cpuPkg::*; (
    input  logic fast_clock,
    input  logic reset,
    input  decodedOp_t op,
    input  logic busDone,
    input  logic [dataWidth-1:0] busData,
    input  logic [addrWidth-1:0] currentPc,
    input  logic [addrWidth-1:0] effectiveAddress,
    input  logic [dataWidth-1:0] storeData,
    output logic busStart,
    output busRequest_t request,
    output logic latch,
    output logic writeEnable,
    output logic enterPrivileged,
    output logic leavePrivileged,
    output logic privileged,
    output logic halted,
    output logic [dataWidth-1:0] memoryData
);

    typedef enum logic [2:0] {
        stFetchStart, stFetchWait, stDecode, stExecute,
        stMemoryWait, stWriteBack, stHalted
    } seqState_t;

    seqState_t state;
    logic memoryAccess;

    assign memoryAccess = op.isLoad || op.isStore;

    assign busStart = (state == stFetchStart) || ((state == stExecute) && memoryAccess);
    assign latch = (state == stFetchWait) && busDone;
    assign writeEnable = (state == stWriteBack);
    assign enterPrivileged = writeEnable && op.isTrap;
    assign leavePrivileged = writeEnable && op.isReturn;
    assign halted = (state == stHalted);

    always_comb begin
        if (state == stFetchStart) begin
            request.kind = busFetch;
            request.address = currentPc;
            request.storeData = '0;
        end else begin
            request.kind = op.isStore ? busStore : busLoad;
            request.address = effectiveAddress;
            request.storeData = storeData;
        end
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            state <= stFetchStart;
            privileged <= 1'b0;
        end else begin
            case (state)
                stFetchStart: state <= stFetchWait;
                stFetchWait: if (busDone) state <= stDecode;
                stDecode: state <= stExecute;    // Register reads settle here
                stExecute: state <= memoryAccess ? stMemoryWait : stWriteBack;
                stMemoryWait: if (busDone) state <= stWriteBack;
                stWriteBack: begin
                    state <= op.isHalt ? stHalted : stFetchStart;
                    if (enterPrivileged) begin
                        privileged <= 1'b1;
                    end else if (leavePrivileged) begin
                        privileged <= 1'b0;
                    end
                end
                default: state <= stHalted;    // Stays until reset
            endcase
        end
    end

    always_ff @(posedge fast_clock) begin
        if ((state == stMemoryWait) && busDone) begin
            memoryData <= busData;
        end
    end

    assert property (@(posedge fast_clock) disable iff (reset)
        state inside {stFetchStart, stFetchWait, stDecode, stExecute,
                      stMemoryWait, stWriteBack, stHalted});

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module tbTop -o simTop
output=$(./obj_dir/simTop)
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

/* sim/tbChecker.sv */
`timescale 1ns/100ps

module tbChecker import cpuPkg::*; (
    input  logic fast_clock,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic wbAck,
    input  logic [addrWidth-1:0] wbAdr,
    input  logic [dataWidth-1:0] wbDatOut,
    input  logic privileged,
    input  logic halted,
    input  logic [dataWidth+addrWidth+1:0] expected,
    input  int expectCount,
    input  logic endOfTest,
    output int writeIndex,
    output int errorCount,
    output logic checkDone
);

    typedef struct packed {
        logic valid;
        logic privileged;
        logic [addrWidth-1:0] address;
        logic [dataWidth-1:0] data;
    } expectEntry_t;

    expectEntry_t entry;
    logic idleReported;

    assign entry = expected;    // Row picked by writeIndex in tbTop

    task automatic compareValue(input string name, input logic [dataWidth-1:0] want,
                                input logic [dataWidth-1:0] seen);
        if (want !== seen) begin
            $display("Fail %0t %s expected %h actual %h", $time, name, want, seen);
            errorCount = errorCount + 1;
        end
    endtask

    initial begin
        writeIndex = 0;
        errorCount = 0;
        checkDone = 1'b0;
        idleReported = 1'b0;
    end

    // Bus sampled at the falling edge
    always @(negedge fast_clock) begin
        if (endOfTest && !checkDone) begin
            if (writeIndex != expectCount) begin
                $display("Only %0d of %0d expected bus writes were seen",
                         writeIndex, expectCount);
                errorCount = errorCount + 1;
            end
            if (!halted) begin
                $display("The core is not halted at the end of the test");
                errorCount = errorCount + 1;
            end
            checkDone = 1'b1;
        end else if (wbCyc && wbStb && wbWe && wbAck) begin
            if (!entry.valid) begin
                $display("Unexpected bus write at %0t to address %h", $time, wbAdr);
                errorCount = errorCount + 1;
            end else begin
                compareValue("wbAdr", dataWidth'(entry.address), dataWidth'(wbAdr));
                compareValue("wbDatOut", entry.data, wbDatOut);
                compareValue("privileged", dataWidth'(entry.privileged),
                             dataWidth'(privileged));
            end
            writeIndex = writeIndex + 1;
        end

        // HALT must leave the bus quiet
        if (halted && wbCyc && !idleReported) begin
            $display("A bus cycle is open at %0t while the core is halted", $time);
            errorCount = errorCount + 1;
            idleReported = 1'b1;
        end
    end

endmodule

/* sim/tbTop.sv */
`timescale 1ns/100ps

module tbTop import cpuPkg::*; ();

    localparam int maxRows = 64;
    localparam int maxWrites = 32;
    localparam int waitPattern [6] = '{0, 2, 1, 0, 1, 2};    // Ack wait states in a cycle
    localparam logic [dataWidth-1:0] valueA = 32'h0000_1234;
    localparam logic [dataWidth-1:0] valueB = 32'hFFFF_FFF9;    // -7

    typedef struct packed {
        logic valid;
        logic privileged;
        logic [addrWidth-1:0] address;
        logic [dataWidth-1:0] data;
    } expectEntry_t;

    logic fast_clock;
    logic reset;
    logic wbAck;
    logic [dataWidth-1:0] wbDatIn;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [addrWidth-1:0] wbAdr;
    logic [dataWidth-1:0] wbDatOut;
    logic privileged;
    logic halted;
    logic endOfTest;
    logic checkDone;
    logic tableReady;
    logic transferOpen;
    int writeIndex;
    int errorCount;
    int rowCount;
    int expectCount;
    int patternIndex;
    int waitLeft;

    logic [dataWidth-1:0] memory [0:(1 << addrWidth) - 1];
    logic [addrWidth-1:0] programAddress [maxRows];
    logic [dataWidth-1:0] programWord [maxRows];
    expectEntry_t expectTable [maxWrites];
    expectEntry_t expectedNow;

    cpuCore dut0 (
        .fast_clock(fast_clock), .reset(reset), .wbAck(wbAck), .wbDatIn(wbDatIn),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatOut(wbDatOut),
        .privileged(privileged), .halted(halted)
    );

    tbChecker checker0 (
        .fast_clock(fast_clock), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAck(wbAck), .wbAdr(wbAdr), .wbDatOut(wbDatOut), .privileged(privileged),
        .halted(halted), .expected(expectedNow), .expectCount(expectCount),
        .endOfTest(endOfTest), .writeIndex(writeIndex), .errorCount(errorCount),
        .checkDone(checkDone)
    );

    assign expectedNow = (writeIndex < expectCount) ? expectTable[writeIndex] : '0;

    function automatic logic [dataWidth-1:0] encodeRegister(opcode_t code, int rd,
                                                            int rsA, int rsB);
        return {code, 4'(rd), 4'(rsA), 4'(rsB), 16'h0000};
    endfunction

    function automatic logic [dataWidth-1:0] encodeImmediate(opcode_t code, int rd,
                                                             int rsA, int imm);
        return {code, 4'(rd), 4'(rsA), 4'h0, 16'(imm)};
    endfunction

    // Background contents unique to every word address
    function automatic logic [dataWidth-1:0] fillValue(int address);
        return {4'hA, 14'(address), 14'(address)};
    endfunction

    task automatic placeInstruction(input int address, input logic [dataWidth-1:0] word);
        programAddress[rowCount] = addrWidth'(address);
        programWord[rowCount] = word;
        rowCount = rowCount + 1;
    endtask

    task automatic placeStore(input int address, input logic [dataWidth-1:0] word,
                              input int storeAddress, input logic [dataWidth-1:0] storeData,
                              input int storePriv);
        placeInstruction(address, word);
        expectTable[expectCount] = '{1'b1, storePriv != 0, addrWidth'(storeAddress), storeData};
        expectCount = expectCount + 1;
    endtask

    // Rows in execution order
    task automatic buildProgram();
        placeStore(0, encodeImmediate(opStore, 0, 0, 0), 'h200, 32'h0000_0200, 0);
        placeStore(1, encodeImmediate(opStore, 14, 0, 1), 'h201, 32'hFFFF_FFFF, 0);
        placeInstruction(2, encodeRegister(opSub, 2, 0, 0));    // r2 = 0
        placeInstruction(3, encodeImmediate(opAddi, 1, 2, 'h1234));
        placeInstruction(4, encodeImmediate(opAddi, 3, 2, -7));
        placeStore(5, encodeImmediate(opStore, 1, 0, 2), 'h202, valueA, 0);
        placeInstruction(6, encodeRegister(opAdd, 4, 1, 3));
        placeStore(7, encodeImmediate(opStore, 4, 0, 3), 'h203, valueA + valueB, 0);
        placeInstruction(8, encodeRegister(opSub, 4, 1, 3));
        placeStore(9, encodeImmediate(opStore, 4, 0, 4), 'h204, valueA - valueB, 0);
        placeInstruction(10, encodeRegister(opAnd, 4, 1, 3));
        placeStore(11, encodeImmediate(opStore, 4, 0, 5), 'h205, valueA & valueB, 0);
        placeInstruction(12, encodeRegister(opOr, 4, 1, 3));
        placeStore(13, encodeImmediate(opStore, 4, 0, 6), 'h206, valueA | valueB, 0);
        placeInstruction(14, encodeRegister(opXor, 4, 1, 3));
        placeStore(15, encodeImmediate(opStore, 4, 0, 7), 'h207, valueA ^ valueB, 0);
        placeInstruction(16, encodeImmediate(opAddi, 6, 2, 'h300));
        placeInstruction(17, encodeImmediate(opLoad, 5, 6, -16));    // From 0x2F0
        placeStore(18, encodeImmediate(opStore, 5, 6, 1), 'h301, fillValue('h2F0), 0);
        placeInstruction(19, encodeImmediate(opLoad, 7, 0, 3));
        placeStore(20, encodeImmediate(opStore, 7, 6, 2), 'h302, valueA + valueB, 0);
        placeInstruction(21, encodeImmediate(opBeqz, 0, 1, 2));    // Not taken
        placeStore(22, encodeImmediate(opStore, 1, 0, 8), 'h208, valueA, 0);
        placeInstruction(23, encodeImmediate(opBeqz, 0, 2, 1));    // Taken so 24 is skipped
        placeInstruction(24, encodeImmediate(opStore, 3, 0, 9));
        placeStore(25, encodeImmediate(opStore, 2, 0, 10), 'h20A, 0, 0);
        placeInstruction(26, encodeRegister(opTrap, 0, 0, 0));
        placeStore('h100, encodeImmediate(opStore, 13, 0, 11), 'h20B, 27, 1);
        placeStore('h101, encodeImmediate(opStore, 14, 0, 12), 'h20C, 32'hFFFF_FFFF, 1);
        placeInstruction('h102, encodeImmediate(opAddi, 14, 2, 'h55));
        placeStore('h103, encodeImmediate(opStore, 14, 0, 13), 'h20D, 'h55, 1);
        placeInstruction('h104, encodeRegister(opRtu, 0, 0, 0));
        placeStore(27, encodeImmediate(opStore, 14, 0, 14), 'h20E, 32'hFFFF_FFFF, 0);
        placeInstruction(28, encodeImmediate(opAddi, 15, 2, 'h30));    // Dropped
        placeStore(29, encodeImmediate(opStore, 15, 0, 15), 'h20F, 30, 0);
        placeInstruction(30, encodeRegister(opHalt, 0, 0, 0));
        placeInstruction(31, encodeImmediate(opStore, 1, 0, 16));    // Never reached
    endtask

    initial begin
        fast_clock = 1'b0;
        forever #4 fast_clock = ~fast_clock;
    end

    // Wishbone slave memory with 0 to 2 wait states before ack
    always @(posedge fast_clock) begin
        #1;
        if (wbAck) begin
            wbAck = 1'b0;
            transferOpen = 1'b0;
        end else if (!reset && wbCyc && wbStb) begin
            if (!transferOpen) begin
                transferOpen = 1'b1;
                waitLeft = waitPattern[patternIndex];
                patternIndex = (patternIndex + 1) % 6;
            end
            if (waitLeft == 0) begin
                wbAck = 1'b1;
                if (wbWe) begin
                    memory[wbAdr] = wbDatOut;
                end else begin
                    wbDatIn = memory[wbAdr];
                end
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    initial begin
        reset = 1'b1;
        wbAck = 1'b0;
        wbDatIn = '0;
        endOfTest = 1'b0;
        tableReady = 1'b0;
        transferOpen = 1'b0;
        rowCount = 0;
        expectCount = 0;
        patternIndex = 0;
        waitLeft = 0;
        buildProgram();
        for (int i = 0; i < (1 << addrWidth); i++) begin
            memory[i] = fillValue(i);
        end
        for (int i = 0; i < rowCount; i++) begin
            memory[programAddress[i]] = programWord[i];
        end
        tableReady = 1'b1;
        repeat (16) @(posedge fast_clock);
        #1 reset = 1'b0;
        wait (halted);
        repeat (20) @(posedge fast_clock);    // Bus has to stay idle meanwhile
        #1 endOfTest = 1'b1;
        wait (checkDone);
        $display("Errors: %0d, timeouts: 0", errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (tableReady);
        repeat (rowCount * 12 + 200) @(posedge fast_clock);
        $display("Timeout after %0d cycles, the core never reached HALT", rowCount * 12 + 200);
        $display("Errors: %0d, timeouts: 1", errorCount);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog.f */
rtl/cpuPkg.sv
rtl/registerBank.sv
rtl/instructionDecoder.sv
rtl/executeUnit.sv
rtl/busInterface.sv
rtl/sequencer.sv
rtl/cpuCore.sv
sim/tbChecker.sv
sim/tbTop.sv
